/* common/tenthirty_pkg.sv */
package tenthirty_pkg;

	// ==================================================
	// sizes and game limits
	// ==================================================
	localparam int card_w     = 4;
	localparam int total_w    = 6;
	localparam int max_cards  = 5;
	// totals count half points so 10.5 is 21
	localparam int bust_limit = 21;
	localparam int face_min   = 11;
	localparam int last_round = 4;

	typedef enum logic [2:0] {
		st_idle,
		st_deal_player,
		st_player_turn,
		st_deal_dealer,
		st_dealer_turn,
		st_compare,
		st_done
	} game_state_e;

	typedef enum logic {
		seat_player,
		seat_dealer
	} seat_e;

	// control bus from the FSM to every later stage
	typedef struct packed {
		game_state_e state;
		seat_e       seat;
		logic        draw;
		logic        clear;
	} turn_ctl_t;

	typedef struct packed {
		logic [total_w-1:0]               total;
		logic [2:0]                       count;
		logic [max_cards-1:0][card_w-1:0] cards;
	} hand_t;

	// digit 0 in the low byte
	typedef logic [7:0][7:0] seg_frame_t;

	// ==================================================
	// seven-segment patterns
	// ==================================================
	// bit 7 drives the decimal point
	localparam logic [7:0] seg_digit [10] = '{
		8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66,
		8'h6d, 8'h7d, 8'h07, 8'h7f, 8'h6f
	};
	localparam logic [7:0] seg_point = 8'h80;
	localparam logic [7:0] seg_dash  = 8'h40;

	// ten shows as '0', face cards as a lone point
	function automatic logic [7:0] seg_card(input logic [card_w-1:0] card);
		logic [7:0] seg;
		if (card >= face_min) begin
			seg = seg_point;
		end else if (card >= 10) begin
			seg = seg_digit[0];
		end else begin
			seg = seg_digit[card];
		end
		return seg;
	endfunction

endpackage

/* rtl/game_ctrl.sv */
`timescale 1ns/1ps

module game_ctrl (
	input  logic                     d_clk,
	input  logic                     rst_n,
	input  logic                     btn_m,
	input  logic                     btn_r,
	input  logic                     hand_closed,
	output tenthirty_pkg::turn_ctl_t ctl
);

	import tenthirty_pkg::*;

	logic        btn_m_q;
	logic        btn_r_q;
	logic        m_press;
	logic        r_press;
	logic        in_turn;
	game_state_e state;
	game_state_e next_state;
	seat_e       seat;
	logic        draw_q;
	logic        clear_q;
	logic [2:0]  round_cnt;

	// rising edge of each button
	always_ff @(posedge d_clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_m_q <= 1'b0;
			btn_r_q <= 1'b0;
		end else begin
			btn_m_q <= btn_m;
			btn_r_q <= btn_r;
		end
	end

	assign m_press = btn_m & ~btn_m_q;
	assign r_press = btn_r & ~btn_r_q;
	assign in_turn = (state == st_player_turn) || (state == st_dealer_turn);

	// ==================================================
	// round FSM
	// ==================================================
	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (m_press) begin
					next_state = st_deal_player;
				end
			end
			st_deal_player: next_state = st_player_turn;
			st_player_turn: begin
				if (r_press || hand_closed) begin
					next_state = st_deal_dealer;
				end
			end
			st_deal_dealer: next_state = st_dealer_turn;
			st_dealer_turn: begin
				if (r_press || hand_closed) begin
					next_state = st_compare;
				end
			end
			st_compare: begin
				if (r_press) begin
					next_state = (round_cnt == last_round) ? st_done : st_idle;
				end
			end
			st_done: next_state = st_done;
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge d_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			draw_q    <= 1'b0;
			clear_q   <= 1'b0;
			round_cnt <= '0;
		end else begin
			state   <= next_state;
			// one card per deal state, then one per press on an open hand
			draw_q  <= (state == st_deal_player) || (state == st_deal_dealer) ||
				(in_turn && m_press && !hand_closed && !draw_q && next_state == state);
			clear_q <= (next_state != state) &&
				(next_state == st_idle || next_state == st_deal_player);
			if (state == st_dealer_turn && next_state != st_dealer_turn) begin
				round_cnt <= round_cnt + 3'd1;
			end
		end
	end

	// dealer owns the seat from its deal onward
	assign seat = (state == st_deal_dealer || state == st_dealer_turn ||
		state == st_compare || state == st_done) ? seat_dealer : seat_player;

	assign ctl = '{state: state, seat: seat, draw: draw_q, clear: clear_q};

endmodule

/* rtl/hand_scorer.sv */
`timescale 1ns/1ps

module hand_scorer (
	input  logic                             d_clk,
	input  logic                             rst_n,
	input  tenthirty_pkg::turn_ctl_t         ctl,
	input  logic [tenthirty_pkg::card_w-1:0] card,
	output tenthirty_pkg::hand_t             player_hand,
	output tenthirty_pkg::hand_t             dealer_hand,
	output logic                             hand_closed
);

	import tenthirty_pkg::*;

	hand_t              hand_q [2];
	hand_t              active;
	hand_t              added;
	logic [total_w-1:0] card_pts;

	assign active = hand_q[ctl.seat];

	// face cards add one half point, others twice their value
	assign card_pts = (card >= face_min) ? total_w'(1) : total_w'({card, 1'b0});

	// active hand with the incoming card placed in its next slot
	always_comb begin
		added = active;
		if (active.count < max_cards) begin
			added.cards[active.count] = card;
		end
		added.total = active.total + card_pts;
		added.count = active.count + 3'd1;
	end

	// ==================================================
	// hand registers
	// ==================================================
	always_ff @(posedge d_clk or negedge rst_n) begin
		if (!rst_n) begin
			hand_q[seat_player] <= '0;
			hand_q[seat_dealer] <= '0;
		end else if (ctl.clear) begin
			hand_q[seat_player] <= '0;
			hand_q[seat_dealer] <= '0;
		end else if (ctl.draw) begin
			hand_q[ctl.seat] <= added;
		end
	end

	assign player_hand = hand_q[seat_player];
	assign dealer_hand = hand_q[seat_dealer];

	// full hand or bust ends the turn
	assign hand_closed = (active.count == max_cards) || (active.total > bust_limit);

endmodule

/* rtl/round_judge.sv */
`timescale 1ns/1ps

module round_judge (
	input  logic                     d_clk,
	input  logic                     rst_n,
	input  tenthirty_pkg::turn_ctl_t ctl,
	input  tenthirty_pkg::hand_t     player_hand,
	input  tenthirty_pkg::hand_t     dealer_hand,
	output logic [2:0]               led
);

	import tenthirty_pkg::*;

	logic player_bust;
	logic dealer_bust;
	logic player_five;
	logic dealer_five;
	logic player_wins;

	assign player_bust = player_hand.total > bust_limit;
	assign dealer_bust = dealer_hand.total > bust_limit;
	assign player_five = player_hand.count == max_cards;
	assign dealer_five = dealer_hand.count == max_cards;

	// first matching rule decides, a tie goes to the dealer
	always_comb begin
		if (dealer_five && !dealer_bust) begin
			player_wins = 1'b0;
		end else if (player_five && !player_bust) begin
			player_wins = 1'b1;
		end else if (player_bust) begin
			player_wins = 1'b0;
		end else if (dealer_bust) begin
			player_wins = 1'b1;
		end else begin
			player_wins = player_hand.total > dealer_hand.total;
		end
	end

	// led0 player, led1 dealer, led2 game over
	always_ff @(posedge d_clk or negedge rst_n) begin
		if (!rst_n) begin
			led <= 3'b000;
		end else begin
			case (ctl.state)
				st_compare: led <= player_wins ? 3'b001 : 3'b010;
				st_done:    led <= 3'b100;
				default:    led <= 3'b000;
			endcase
		end
	end

endmodule

/* display/seg_frame_builder.sv */
`timescale 1ns/1ps

module seg_frame_builder (
	input  logic                      d_clk,
	input  logic                      rst_n,
	input  tenthirty_pkg::turn_ctl_t  ctl,
	input  tenthirty_pkg::hand_t      player_hand,
	input  tenthirty_pkg::hand_t      dealer_hand,
	output tenthirty_pkg::seg_frame_t frame
);

	import tenthirty_pkg::*;

	// dashes on digits 0 to 5, "00" on the left pair
	localparam seg_frame_t idle_frame = {seg_digit[0], seg_digit[0], {6{seg_dash}}};

	hand_t      shown;
	seg_frame_t frame_d;

	// half point, units and tens of a total, low digit first
	function automatic logic [2:0][7:0] total_segs(input logic [total_w-1:0] total);
		logic [total_w-2:0] whole;
		logic [2:0][7:0]    segs;
		whole   = total[total_w-1:1];
		segs[0] = total[0] ? seg_point : seg_dash;
		segs[1] = seg_digit[whole % 10];
		segs[2] = seg_digit[whole / 10];
		return segs;
	endfunction

	assign shown = (ctl.seat == seat_dealer) ? dealer_hand : player_hand;

	// ==================================================
	// frame per state
	// ==================================================
	always_comb begin
		frame_d = idle_frame;
		case (ctl.state)
			st_deal_player, st_player_turn, st_deal_dealer, st_dealer_turn: begin
				// cards of the seat in play, dash for an empty slot
				for (int i = 0; i < max_cards; i++) begin
					frame_d[i] = (i < shown.count) ? seg_card(shown.cards[i]) : seg_dash;
				end
				frame_d[7:5] = total_segs(shown.total);
			end
			st_compare, st_done: begin
				frame_d[2:0] = total_segs(player_hand.total);
				frame_d[4:3] = {seg_dash, seg_dash};
				frame_d[7:5] = total_segs(dealer_hand.total);
			end
			default: frame_d = idle_frame;
		endcase
	end

	always_ff @(posedge d_clk or negedge rst_n) begin
		if (!rst_n) begin
			frame <= idle_frame;
		end else begin
			frame <= frame_d;
		end
	end

endmodule

/* rtl/tenthirty_top.sv */
`timescale 1ns/1ps

module tenthirty_top (
	input  logic                             d_clk,
	input  logic                             rst_n,
	input  logic                             btn_m,
	input  logic                             btn_r,
	input  logic [tenthirty_pkg::card_w-1:0] card,
	output logic                             draw,
	output logic [2:0]                       led,
	output tenthirty_pkg::seg_frame_t        frame
);

	import tenthirty_pkg::*;

	turn_ctl_t ctl;
	hand_t     player_hand;
	hand_t     dealer_hand;
	logic      hand_closed;

	// card request strobe straight off the control bus
	assign draw = ctl.draw;

	game_ctrl game_ctrl_inst (
		.d_clk       (d_clk),
		.rst_n       (rst_n),
		.btn_m       (btn_m),
		.btn_r       (btn_r),
		.hand_closed (hand_closed),
		.ctl         (ctl)
	);

	hand_scorer hand_scorer_inst (
		.d_clk       (d_clk),
		.rst_n       (rst_n),
		.ctl         (ctl),
		.card        (card),
		.player_hand (player_hand),
		.dealer_hand (dealer_hand),
		.hand_closed (hand_closed)
	);

	round_judge round_judge_inst (
		.d_clk       (d_clk),
		.rst_n       (rst_n),
		.ctl         (ctl),
		.player_hand (player_hand),
		.dealer_hand (dealer_hand),
		.led         (led)
	);

	seg_frame_builder seg_frame_builder_inst (
		.d_clk       (d_clk),
		.rst_n       (rst_n),
		.ctl         (ctl),
		.player_hand (player_hand),
		.dealer_hand (dealer_hand),
		.frame       (frame)
	);

endmodule

/* dv/tenthirty_checker.sv */
`timescale 1ns/1ps

module tenthirty_checker (
	input logic                       d_clk,
	input logic                       rst_n,
	input logic                       draw,
	input logic [2:0]                 led,
	input tenthirty_pkg::game_state_e state
);

	import tenthirty_pkg::*;

	// a card request lasts one cycle
	draw_single_cycle: assert property (@(posedge d_clk) disable iff (!rst_n)
		draw |=> !draw)
		else $error("draw stayed high for two cycles");

	led_at_most_one: assert property (@(posedge d_clk) disable iff (!rst_n)
		$onehot0(led))
		else $error("more than one led lit");

	// cards only go out in deal and turn states
	draw_in_play: assert property (@(posedge d_clk) disable iff (!rst_n)
		draw |-> !(state inside {st_idle, st_compare, st_done}))
		else $error("draw raised outside a deal or turn");

endmodule

bind tenthirty_top tenthirty_checker tenthirty_checker_inst (
	.d_clk (d_clk),
	.rst_n (rst_n),
	.draw  (draw),
	.led   (led),
	.state (ctl.state)
);

/* dv/tenthirty_tb.sv */
`timescale 1ns/1ps

module tenthirty_tb;

	import tenthirty_pkg::*;

	localparam int clk_period       = 100;
	localparam int num_rounds       = 4;
	localparam int max_round_cycles = 80;

	logic              d_clk;
	logic              rst_n;
	logic              btn_m;
	logic              btn_r;
	logic [card_w-1:0] card;
	logic              draw;
	logic [2:0]        led;
	seg_frame_t        frame;

	logic [31:0] lfsr;
	int          seat_now;
	int          m_cards [2][5];
	int          m_total [2];
	int          m_count [2];
	int          turn_draws;
	int          exp_draws;

	tenthirty_top tenthirty_top_inst (
		.d_clk (d_clk),
		.rst_n (rst_n),
		.btn_m (btn_m),
		.btn_r (btn_r),
		.card  (card),
		.draw  (draw),
		.led   (led),
		.frame (frame)
	);

	initial begin
		d_clk = 1'b0;
		forever #(clk_period / 2) d_clk = ~d_clk;
	end

	initial begin
		#(clk_period * (num_rounds * max_round_cycles + 40));
		$display("timeout: the game never finished its %0d rounds", num_rounds);
		$display("test failed");
		$fatal(1);
	end

	// ==================================================
	// random source and reference model
	// ==================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val  = (val << 1) | lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [7:0] digit_seg(input int d);
		case (d)
			0: return 8'h3f;
			1: return 8'h06;
			2: return 8'h5b;
			3: return 8'h4f;
			4: return 8'h66;
			5: return 8'h6d;
			6: return 8'h7d;
			7: return 8'h07;
			8: return 8'h7f;
			default: return 8'h6f;
		endcase
	endfunction

	// face cards light the point, a ten shows as '0'
	function automatic logic [7:0] card_seg(input int c);
		return (c >= 11) ? 8'h80 : digit_seg(c % 10);
	endfunction

	function automatic seg_frame_t turn_frame(input int s);
		seg_frame_t f;
		for (int i = 0; i < 5; i++) begin
			f[i] = (i < m_count[s]) ? card_seg(m_cards[s][i]) : 8'h40;
		end
		f[5] = (m_total[s] % 2 == 1) ? 8'h80 : 8'h40;
		f[6] = digit_seg((m_total[s] / 2) % 10);
		f[7] = digit_seg(m_total[s] / 20);
		return f;
	endfunction

	// player on digits 0 to 2, dealer on 5 to 7
	function automatic seg_frame_t score_frame();
		seg_frame_t f;
		for (int s = 0; s < 2; s++) begin
			f[s * 5]     = (m_total[s] % 2 == 1) ? 8'h80 : 8'h40;
			f[s * 5 + 1] = digit_seg((m_total[s] / 2) % 10);
			f[s * 5 + 2] = digit_seg(m_total[s] / 20);
		end
		f[3] = 8'h40;
		f[4] = 8'h40;
		return f;
	endfunction

	function automatic seg_frame_t idle_frame();
		seg_frame_t f;
		for (int i = 0; i < 8; i++) begin
			f[i] = (i < 6) ? 8'h40 : digit_seg(0);
		end
		return f;
	endfunction

	function automatic bit hand_open(input int s);
		return (m_count[s] < 5) && (m_total[s] <= 21);
	endfunction

	function automatic logic [2:0] expected_led();
		bit p_bust;
		bit d_bust;
		p_bust = m_total[0] > 21;
		d_bust = m_total[1] > 21;
		if (m_count[1] == 5 && !d_bust) return 3'b010;
		if (m_count[0] == 5 && !p_bust) return 3'b001;
		if (p_bust) return 3'b010;
		if (d_bust) return 3'b001;
		return (m_total[0] > m_total[1]) ? 3'b001 : 3'b010;
	endfunction

	// ==================================================
	// stimulus and checks
	// ==================================================
	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else begin
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// one clock, then the deck answers a draw in the same cycle
	task automatic tick();
		int val;
		int c;
		@(posedge d_clk);
		#1;
		if (draw) begin
			take_bits(4, val);
			c    = val % 13 + 1;
			card = card_w'(c);
			if (m_count[seat_now] < 5) begin
				m_cards[seat_now][m_count[seat_now]] = c;
			end
			m_total[seat_now] += (c >= 11) ? 1 : 2 * c;
			m_count[seat_now]++;
			turn_draws++;
		end
	endtask

	// low for a cycle, high for a cycle, then released
	task automatic press(input bit use_m);
		btn_m = 1'b0;
		btn_r = 1'b0;
		tick();
		if (use_m) begin
			btn_m = 1'b1;
		end else begin
			btn_r = 1'b1;
		end
		tick();
		btn_m = 1'b0;
		btn_r = 1'b0;
	endtask

	// hit or stand until the hand closes
	task automatic take_turn(input int s, input string name);
		int hit;
		check_val({name, " deal draw"}, 1, draw);
		exp_draws = 1;
		tick();
		tick();
		check_val({name, " frame"}, turn_frame(s), frame);
		while (hand_open(s)) begin
			take_bits(1, hit);
			if (hit == 0) begin
				press(1'b0);
				break;
			end
			press(1'b1);
			exp_draws++;
			check_val({name, " hit draw"}, 1, draw);
			tick();
			tick();
			check_val({name, " frame"}, turn_frame(s), frame);
		end
		check_val({name, " draws"}, exp_draws, turn_draws);
	endtask

	task automatic run_round(input int r);
		for (int s = 0; s < 2; s++) begin
			m_total[s] = 0;
			m_count[s] = 0;
		end
		seat_now   = 0;
		turn_draws = 0;
		press(1'b1);
		check_val("idle press draw", 0, draw);
		tick();
		take_turn(0, "player");
		seat_now   = 1;
		turn_draws = 0;
		tick();
		take_turn(1, "dealer");
		tick();
		check_val("compare led", expected_led(), led);
		check_val("compare frame", score_frame(), frame);
		// no card is dealt at compare
		press(1'b1);
		check_val("compare draw", 0, draw);
		press(1'b0);
		tick();
		if (r < num_rounds) begin
			check_val("idle led", 0, led);
			check_val("idle frame", idle_frame(), frame);
		end else begin
			check_val("done led", 3'b100, led);
		end
	endtask

	initial begin
		lfsr       = 32'h7e5a_6295;
		rst_n      = 1'b0;
		btn_m      = 1'b0;
		btn_r      = 1'b0;
		card       = '0;
		seat_now   = 0;
		turn_draws = 0;
		exp_draws  = 0;
		repeat (5) @(posedge d_clk);
		#1;
		rst_n = 1'b1;
		check_val("reset led", 0, led);
		check_val("reset draw", 0, draw);
		check_val("reset frame", idle_frame(), frame);
		for (int r = 1; r <= num_rounds; r++) begin
			run_round(r);
		end
		// game over holds until reset
		repeat (4) begin
			tick();
			check_val("done led", 3'b100, led);
			check_val("done draw", 0, draw);
		end
		$display("test passed");
		$finish;
	end

endmodule

/* all.f */
common/tenthirty_pkg.sv
rtl/game_ctrl.sv
rtl/hand_scorer.sv
rtl/round_judge.sv
display/seg_frame_builder.sv
rtl/tenthirty_top.sv
dv/tenthirty_checker.sv
dv/tenthirty_tb.sv

/* Bender.yml */
package:
  name: tenthirty

sources:
  - files:
      - common/tenthirty_pkg.sv
      - rtl/game_ctrl.sv
      - rtl/hand_scorer.sv
      - rtl/round_judge.sv
      - display/seg_frame_builder.sv
      - rtl/tenthirty_top.sv
  - target: simulation
    files:
      - dv/tenthirty_checker.sv
      - dv/tenthirty_tb.sv
